//--- design/rp_consts.svh
`ifndef RP_CONSTS_SVH
`define RP_CONSTS_SVH

// host bus geometry
`define RP_ADR_W        16
`define RP_DAT_W        32

// region field of the byte address
`define RP_REGION_MSB   15
`define RP_REGION_LSB   12
`define RP_REGION_HK    0             // housekeeping
`define RP_REGION_PWM   1             // pwm analog outputs

// converter and sample widths
`define RP_ADC_RAW_W    16            // raw word, lowest 2 bits unused
`define RP_SMP_W        14

// housekeeping word offsets, byte address is offset * 4
`define RP_HK_ID        0
`define RP_HK_LED       1
`define RP_HK_CTRL      2
`define RP_HK_OFS_A     3
`define RP_HK_OFS_B     4             // must follow OFS_A
`define RP_HK_ID_VALUE  32'h5250_0a01 // board identifier

// control register bits
`define RP_CTRL_LOOP_BIT 0            // digital loopback
`define RP_CTRL_FT_A_BIT 1            // feedthrough ch a
`define RP_CTRL_FT_B_BIT 2            // feedthrough ch b

// pwm outputs, period is 2**RP_PWM_W cycles
`define RP_PWM_N        4
`define RP_PWM_W        8

`endif

//--- design/rp_bus_pkg.sv
`include "rp_consts.svh"

// types of the register bus between host, decoder and slaves
package rp_bus_pkg;

  // byte address, region field on top
  typedef logic [`RP_ADR_W-1:0] bus_adr_t;

  // read and write data word
  typedef logic [`RP_DAT_W-1:0] bus_dat_t;

  // one select per data byte
  typedef logic [`RP_DAT_W/8-1:0] bus_sel_t;

endpackage : rp_bus_pkg

//--- design/rp_sample_pkg.sv
`include "rp_consts.svh"

// types of the analog data path and the pwm outputs
package rp_sample_pkg;

  // converter word as it comes from the pins
  typedef logic [`RP_ADC_RAW_W-1:0] adc_raw_t;

  // two's complement sample
  typedef logic signed [`RP_SMP_W-1:0] smp_t;

  // word driven to the dac pins
  typedef logic [`RP_SMP_W-1:0] dac_code_t;

  // pwm duty, high cycles per period
  typedef logic [`RP_PWM_W-1:0] pwm_duty_t;

endpackage : rp_sample_pkg

//--- design/rp_bus_decoder.sv
`timescale 1ns/1ps
`include "rp_consts.svh"

module rp_bus_decoder (
  input  logic                 adc_clk,
  input  logic                 reset_i,
  // host side, wishbone classic
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  rp_bus_pkg::bus_adr_t wb_adr_i,
  output rp_bus_pkg::bus_dat_t wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  // slave side
  output logic                 hk_stb_o,
  output logic                 pwm_stb_o,
  input  logic                 hk_ack_i,
  input  logic                 pwm_ack_i,
  input  rp_bus_pkg::bus_dat_t hk_dat_i,
  input  rp_bus_pkg::bus_dat_t pwm_dat_i
);
  import rp_bus_pkg::*;

  localparam int REG_W = `RP_REGION_MSB - `RP_REGION_LSB + 1;

  logic [REG_W-1:0] region;    // top address bits
  logic             req;       // host request pending
  logic             hit_hk;
  logic             hit_pwm;
  logic             miss;      // nobody lives there
  logic             err_q;
  bus_dat_t         rd_dat;    // muxed slave data

  //////////////////////////////////////////////////////////////////////
  // region decode and strobe steering
  //////////////////////////////////////////////////////////////////////

  assign region  = wb_adr_i[`RP_REGION_MSB:`RP_REGION_LSB];
  assign req     = wb_cyc_i & wb_stb_i;
  assign hit_hk  = (region == REG_W'(`RP_REGION_HK));
  assign hit_pwm = (region == REG_W'(`RP_REGION_PWM));
  assign miss    = ~hit_hk & ~hit_pwm;

  assign hk_stb_o  = req & hit_hk;   // only one slave sees the strobe
  assign pwm_stb_o = req & hit_pwm;

  //////////////////////////////////////////////////////////////////////
  // error response for unmapped regions
  //////////////////////////////////////////////////////////////////////

  // one cycle late like a slave ack, single pulse on a held strobe
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      err_q <= 1'b0;
    else
      err_q <= req & miss & ~err_q;
  end

  assign wb_err_o = err_q;

  //////////////////////////////////////////////////////////////////////
  // ack and read data back to host
  //////////////////////////////////////////////////////////////////////

  // address is held until ack, so region still picks the right slave
  always_comb
  begin
    if (hit_hk)
    begin
      wb_ack_o = hk_ack_i;
      rd_dat   = hk_dat_i;
    end
    else if (hit_pwm)
    begin
      wb_ack_o = pwm_ack_i;
      rd_dat   = pwm_dat_i;
    end
    else
    begin
      wb_ack_o = 1'b0;       // err answers instead
      rd_dat   = '0;
    end
  end

  assign wb_dat_o = wb_we_i ? '0 : rd_dat;   // data only on reads

endmodule : rp_bus_decoder

//--- design/rp_housekeeping.sv
`timescale 1ns/1ps
`include "rp_consts.svh"

module rp_housekeeping (
  input  logic                 adc_clk,
  input  logic                 reset_i,
  // register bus slave port
  input  logic                 stb_i,
  input  logic                 we_i,
  input  rp_bus_pkg::bus_adr_t adr_i,
  input  rp_bus_pkg::bus_sel_t sel_i,
  input  rp_bus_pkg::bus_dat_t dat_i,
  output rp_bus_pkg::bus_dat_t dat_o,
  output logic                 ack_o,
  // board controls
  output logic [8-1:0]         led_o,
  output logic                 digital_loop_o,
  output logic                 feed_a_o,
  output logic                 feed_b_o,
  output rp_sample_pkg::smp_t  offset_a_o,
  output rp_sample_pkg::smp_t  offset_b_o
);
  import rp_bus_pkg::*;
  import rp_sample_pkg::*;

  localparam int WRD_W  = `RP_REGION_LSB - 2;       // word offset inside region
  localparam int CTRL_W = `RP_CTRL_FT_B_BIT + 1;

  logic [WRD_W-1:0]  word;
  logic              acc;        // access accepted this cycle
  logic [8-1:0]      led_q;
  logic [CTRL_W-1:0] ctrl_q;
  smp_t              ofs_q [2];  // output offsets a, b
  bus_dat_t          rd_dat;

  assign word = adr_i[`RP_REGION_LSB-1:2];  // byte lanes dropped
  assign acc  = stb_i & ~ack_o;             // no second ack on a held strobe

  //////////////////////////////////////////////////////////////////////
  // register writes, byte selects applied
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      led_q  <= '0;
      ctrl_q <= '0;
      ofs_q  <= '{default: '0};
    end
    else if (acc && we_i)
    begin
      if (word == WRD_W'(`RP_HK_LED) && sel_i[0])
        led_q <= dat_i[7:0];
      if (word == WRD_W'(`RP_HK_CTRL) && sel_i[0])
        ctrl_q <= dat_i[CTRL_W-1:0];
      // offset b is the word right after offset a
      for (int c = 0; c < 2; c++)
      begin
        if (word == WRD_W'(`RP_HK_OFS_A + c))
        begin
          if (sel_i[0])
            ofs_q[c][7:0] <= dat_i[7:0];
          if (sel_i[1])
            ofs_q[c][`RP_SMP_W-1:8] <= dat_i[`RP_SMP_W-1:8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read mux and bus response
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (word)
      WRD_W'(`RP_HK_ID):    rd_dat = `RP_HK_ID_VALUE;   // read only
      WRD_W'(`RP_HK_LED):   rd_dat = bus_dat_t'(led_q);
      WRD_W'(`RP_HK_CTRL):  rd_dat = bus_dat_t'(ctrl_q);
      // offsets come back sign extended
      WRD_W'(`RP_HK_OFS_A): rd_dat = {{(`RP_DAT_W-`RP_SMP_W){ofs_q[0][`RP_SMP_W-1]}}, ofs_q[0]};
      WRD_W'(`RP_HK_OFS_B): rd_dat = {{(`RP_DAT_W-`RP_SMP_W){ofs_q[1][`RP_SMP_W-1]}}, ofs_q[1]};
      default:              rd_dat = '0;                 // unknown offset reads 0
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      ack_o <= 1'b0;
      dat_o <= '0;
    end
    else
    begin
      ack_o <= acc;       // single cycle pulse
      if (acc)
        dat_o <= rd_dat;
    end
  end

  assign led_o          = led_q;
  assign digital_loop_o = ctrl_q[`RP_CTRL_LOOP_BIT];
  assign feed_a_o       = ctrl_q[`RP_CTRL_FT_A_BIT];
  assign feed_b_o       = ctrl_q[`RP_CTRL_FT_B_BIT];
  assign offset_a_o     = ofs_q[0];
  assign offset_b_o     = ofs_q[1];

endmodule : rp_housekeeping

//--- design/rp_analog_io.sv
`timescale 1ns/1ps
`include "rp_consts.svh"

module rp_analog_io (
  input  logic                     adc_clk,
  input  logic                     reset_i,
  // converter inputs
  input  rp_sample_pkg::adc_raw_t  adc_dat_a_i,
  input  rp_sample_pkg::adc_raw_t  adc_dat_b_i,
  // controls from housekeeping
  input  logic                     digital_loop_i,
  input  logic                     feed_a_i,
  input  logic                     feed_b_i,
  input  rp_sample_pkg::smp_t      offset_a_i,
  input  rp_sample_pkg::smp_t      offset_b_i,
  // dac pins
  output rp_sample_pkg::dac_code_t dac_dat_a_o,
  output rp_sample_pkg::dac_code_t dac_dat_b_o
);
  import rp_sample_pkg::*;

  localparam int NCH   = 2;
  localparam int SUM_W = `RP_SMP_W + 1;   // one bit of headroom

  adc_raw_t                adc_in  [NCH];
  logic                    feed    [NCH];
  smp_t                    ofs     [NCH];
  logic [`RP_SMP_W-1:0]    raw_q   [NCH];   // captured top bits
  smp_t                    adc_smp [NCH];   // two's complement
  smp_t                    src     [NCH];   // adc or loopback
  smp_t                    gated   [NCH];
  logic signed [SUM_W-1:0] sum     [NCH];
  smp_t                    sat     [NCH];
  smp_t                    dac_q   [NCH];   // signed dac register
  dac_code_t               code    [NCH];

  // gather loose ports into per channel arrays
  assign adc_in[0] = adc_dat_a_i;
  assign adc_in[1] = adc_dat_b_i;
  assign feed[0]   = feed_a_i;
  assign feed[1]   = feed_b_i;
  assign ofs[0]    = offset_a_i;
  assign ofs[1]    = offset_b_i;

  //////////////////////////////////////////////////////////////////////
  // capture and dac registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      raw_q <= '{default: '0};
      dac_q <= '{default: '0};  // signed zero at rest
    end
    else
    begin
      for (int c = 0; c < NCH; c++)
      begin
        raw_q[c] <= adc_in[c][`RP_ADC_RAW_W-1 -: `RP_SMP_W];  // lowest 2 bits unused
        dac_q[c] <= sat[c];  // second edge of the path
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // conversion, loopback, summing point
  //////////////////////////////////////////////////////////////////////

  for (genvar c = 0; c < NCH; c++)
  begin : g_ch
    // negative slope unsigned -> two's complement
    assign adc_smp[c] = {raw_q[c][`RP_SMP_W-1], ~raw_q[c][`RP_SMP_W-2:0]};

    // loopback reads the registered dac value, no comb loop
    assign src[c]   = digital_loop_i ? dac_q[c] : adc_smp[c];
    assign gated[c] = feed[c] ? src[c] : '0;

    // sign extend both terms by one bit
    assign sum[c] = {gated[c][`RP_SMP_W-1], gated[c]} + {ofs[c][`RP_SMP_W-1], ofs[c]};

    // top two bits differ -> overflow, clamp to +8191 or -8192
    assign sat[c] = (sum[c][SUM_W-1] ^ sum[c][SUM_W-2])
                  ? {sum[c][SUM_W-1], {(`RP_SMP_W-1){~sum[c][SUM_W-1]}}}
                  : sum[c][`RP_SMP_W-1:0];

    // same bit flip back out to the dac
    assign code[c] = {dac_q[c][`RP_SMP_W-1], ~dac_q[c][`RP_SMP_W-2:0]};
  end

  assign dac_dat_a_o = code[0];
  assign dac_dat_b_o = code[1];

endmodule : rp_analog_io

//--- design/rp_pwm_dac.sv
`timescale 1ns/1ps
`include "rp_consts.svh"

module rp_pwm_dac (
  input  logic                 adc_clk,
  input  logic                 reset_i,
  // register bus slave port
  input  logic                 stb_i,
  input  logic                 we_i,
  input  rp_bus_pkg::bus_adr_t adr_i,
  input  rp_bus_pkg::bus_dat_t dat_i,
  output rp_bus_pkg::bus_dat_t dat_o,
  output logic                 ack_o,
  // pwm pins
  output logic [`RP_PWM_N-1:0] pwm_o
);
  import rp_bus_pkg::*;
  import rp_sample_pkg::*;

  localparam int WRD_W = `RP_REGION_LSB - 2;
  localparam int IDX_W = $clog2(`RP_PWM_N);

  logic [WRD_W-1:0] word;
  logic [IDX_W-1:0] idx;              // duty register number
  logic             hit;              // offset maps to a duty register
  logic             acc;
  pwm_duty_t        duty_q [`RP_PWM_N];
  pwm_duty_t        cnt_q;            // shared period counter
  bus_dat_t         rd_dat;

  assign word   = adr_i[`RP_REGION_LSB-1:2];
  assign idx    = word[IDX_W-1:0];
  assign hit    = (word < WRD_W'(`RP_PWM_N));   // offsets 0, 4, 8, 12
  assign acc    = stb_i & ~ack_o;
  assign rd_dat = hit ? bus_dat_t'(duty_q[idx]) : '0;

  //////////////////////////////////////////////////////////////////////
  // duty registers on the bus
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      ack_o  <= 1'b0;
      dat_o  <= '0;
      duty_q <= '{default: '0};
    end
    else
    begin
      ack_o <= acc;
      if (acc)
        dat_o <= rd_dat;
      if (acc && we_i && hit)
        duty_q[idx] <= dat_i[`RP_PWM_W-1:0];  // upper bits dropped
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pwm generator
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      cnt_q <= '0;
      pwm_o <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;  // wraps every 256 cycles
      for (int n = 0; n < `RP_PWM_N; n++)
        pwm_o[n] <= (cnt_q < duty_q[n]);   // duty 0 never high
    end
  end

endmodule : rp_pwm_dac

//--- design/rp_top.sv
`timescale 1ns/1ps
`include "rp_consts.svh"

module rp_top (
  input  logic                     adc_clk,
  input  logic                     reset_i,
  // host bus, wishbone classic
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  rp_bus_pkg::bus_adr_t     wb_adr_i,
  input  rp_bus_pkg::bus_sel_t     wb_sel_i,
  input  rp_bus_pkg::bus_dat_t     wb_dat_i,
  output rp_bus_pkg::bus_dat_t     wb_dat_o,
  output logic                     wb_ack_o,
  output logic                     wb_err_o,
  // converters
  input  rp_sample_pkg::adc_raw_t  adc_dat_a_i,
  input  rp_sample_pkg::adc_raw_t  adc_dat_b_i,
  output rp_sample_pkg::dac_code_t dac_dat_a_o,
  output rp_sample_pkg::dac_code_t dac_dat_b_o,
  // pwm and leds
  output logic [`RP_PWM_N-1:0]     pwm_o,
  output logic [8-1:0]             led_o
);
  import rp_bus_pkg::*;
  import rp_sample_pkg::*;

  // decoder <-> slaves
  logic     hk_stb, pwm_stb;
  logic     hk_ack, pwm_ack;
  bus_dat_t hk_dat, pwm_dat;

  // housekeeping -> analog path
  logic     digital_loop, feed_a, feed_b;
  smp_t     offset_a, offset_b;

  //////////////////////////////////////////////////////////////////////
  // bus decoder and slaves
  //////////////////////////////////////////////////////////////////////

  rp_bus_decoder i_dec (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
    .wb_adr_i (wb_adr_i), .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o), .wb_err_o (wb_err_o),
    .hk_stb_o (hk_stb), .pwm_stb_o (pwm_stb),
    .hk_ack_i (hk_ack), .pwm_ack_i (pwm_ack),
    .hk_dat_i (hk_dat), .pwm_dat_i (pwm_dat)
  );

  // address, we, sel and write data shared by both slaves
  rp_housekeeping i_hk (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .stb_i (hk_stb), .we_i (wb_we_i), .adr_i (wb_adr_i),
    .sel_i (wb_sel_i), .dat_i (wb_dat_i), .dat_o (hk_dat), .ack_o (hk_ack),
    .led_o (led_o), .digital_loop_o (digital_loop),
    .feed_a_o (feed_a), .feed_b_o (feed_b),
    .offset_a_o (offset_a), .offset_b_o (offset_b)
  );

  rp_pwm_dac i_pwm (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .stb_i (pwm_stb), .we_i (wb_we_i), .adr_i (wb_adr_i),
    .dat_i (wb_dat_i), .dat_o (pwm_dat), .ack_o (pwm_ack),
    .pwm_o (pwm_o)
  );

  //////////////////////////////////////////////////////////////////////
  // analog path
  //////////////////////////////////////////////////////////////////////

  rp_analog_io i_ams (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .digital_loop_i (digital_loop), .feed_a_i (feed_a), .feed_b_i (feed_b),
    .offset_a_i (offset_a), .offset_b_i (offset_b),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o)
  );

endmodule : rp_top

//--- verif/rp_tb_bus.svh
`ifndef RP_TB_BUS_SVH
`define RP_TB_BUS_SVH

//////////////////////////////////////////////////////////////////////
// random numbers
//////////////////////////////////////////////////////////////////////

// 32 bit xorshift, shifts 13 / 17 / 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// advances the shared generator state
function automatic logic [31:0] next_rand();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

//////////////////////////////////////////////////////////////////////
// reference models of the sample conversions
//////////////////////////////////////////////////////////////////////

// converter word -> signed sample
function automatic int adc_to_smp(input adc_raw_t raw);
  logic [`RP_SMP_W-1:0] top;
  top = raw[`RP_ADC_RAW_W-1 -: `RP_SMP_W];     // top 14 bits only
  top[`RP_SMP_W-2:0] = ~top[`RP_SMP_W-2:0];    // negative slope
  return $signed(top);
endfunction

// signed sample -> dac pin word, same bit flip
function automatic dac_code_t smp_to_code(input int s);
  logic [`RP_SMP_W-1:0] c;
  c = s[`RP_SMP_W-1:0];
  c[`RP_SMP_W-2:0] = ~c[`RP_SMP_W-2:0];
  return c;
endfunction

// dac pin word back to a signed sample
function automatic int code_to_smp(input dac_code_t c);
  logic [`RP_SMP_W-1:0] s;
  s = c;
  s[`RP_SMP_W-2:0] = ~s[`RP_SMP_W-2:0];
  return $signed(s);
endfunction

// plain integer add, then clamp to the sample range
function automatic int clamp_sum(input int a, input int b);
  int s;
  s = a + b;
  if (s > SMP_MAX)
    s = SMP_MAX;
  else if (s < SMP_MIN)
    s = SMP_MIN;
  return s;
endfunction

//////////////////////////////////////////////////////////////////////
// wishbone classic master
//////////////////////////////////////////////////////////////////////

function automatic bus_adr_t reg_addr(input int region, input int word);
  bus_adr_t a;
  a = '0;
  a[`RP_REGION_MSB:`RP_REGION_LSB] = region[`RP_REGION_MSB-`RP_REGION_LSB:0];
  a[`RP_REGION_LSB-1:2] = word[`RP_REGION_LSB-3:0];   // word -> byte address
  return a;
endfunction

// one request, resp 0 ack / 1 err / 2 nothing, lat in cycles
task automatic wb_access(input logic we, input bus_adr_t adr, input bus_dat_t wdat,
                         output bus_dat_t rdat, output int resp, output int lat);
  @(negedge adc_clk);
  wb_cyc_i = 1'b1;
  wb_stb_i = 1'b1;
  wb_we_i  = we;
  wb_adr_i = adr;
  wb_sel_i = '1;
  wb_dat_i = wdat;
  resp = 2;
  lat  = 0;
  rdat = '0;
  while (resp == 2 && lat < BUS_TIMEOUT)
  begin
    @(negedge adc_clk);
    lat++;
    if (wb_ack_o)
    begin
      resp = 0;
      rdat = wb_dat_o;    // address still held here
    end
    else if (wb_err_o)
    begin
      resp = 1;
      rdat = wb_dat_o;
    end
  end
  wb_cyc_i = 1'b0;        // drop the request
  wb_stb_i = 1'b0;
  wb_we_i  = 1'b0;
  assert (resp != 2)
  else
  begin
    $display("%s: bus access to 0x%h got neither ack nor err", cur_test, adr);
    err_cnt++;
  end
  @(negedge adc_clk);     // idle cycle, no second answer
  assert (!wb_ack_o && !wb_err_o)
  else
  begin
    $display("%s: second bus answer after the request was dropped", cur_test);
    err_cnt++;
  end
endtask

// strobe held one cycle past the answer, counts every answer seen
task automatic held_read(input bus_adr_t adr, output int n_ack, output int n_err);
  @(negedge adc_clk);
  wb_cyc_i = 1'b1;
  wb_stb_i = 1'b1;
  wb_we_i  = 1'b0;
  wb_adr_i = adr;
  n_ack    = 0;
  n_err    = 0;
  for (int i = 0; i < 3; i++)
  begin
    @(negedge adc_clk);
    n_ack += wb_ack_o;
    n_err += wb_err_o;
    if (i == 1)
    begin
      wb_cyc_i = 1'b0;    // released after two sampled edges
      wb_stb_i = 1'b0;
    end
  end
endtask

task automatic write_reg(input int region, input int word, input bus_dat_t data);
  bus_dat_t rd;
  int       resp;
  int       lat;
  wb_access(1'b1, reg_addr(region, word), data, rd, resp, lat);
  check_eq("write resp", 0, resp);
  check_eq("write latency", 1, lat);
endtask

task automatic read_reg(input int region, input int word, output bus_dat_t data);
  int resp;
  int lat;
  wb_access(1'b0, reg_addr(region, word), '0, data, resp, lat);
  check_eq("read resp", 0, resp);
  check_eq("read latency", 1, lat);
endtask

`endif

//--- verif/rp_tb.sv
`timescale 1ns/1ps
`include "rp_consts.svh"

module rp_tb;
  import rp_bus_pkg::*;
  import rp_sample_pkg::*;

  localparam int          CLK_NS      = 20;
  localparam int          RST_CYCLES  = 8;
  localparam logic [31:0] SEED        = 32'd81;
  localparam int          BUS_TIMEOUT = 16;     // cycles to wait for ack or err
  localparam int          SMP_MAX     = (1 << (`RP_SMP_W-1)) - 1;
  localparam int          SMP_MIN     = -(1 << (`RP_SMP_W-1));
  localparam int          N_FEED      = 64;
  localparam int          N_SAT       = 10;     // offset batches
  localparam int          SAT_SMPS    = 24;     // samples per batch
  localparam int          LOOP_MAX    = 400;    // cycles to reach the limit
  localparam int          PWM_PERIOD  = 1 << `RP_PWM_W;
  // cycle budget per test
  localparam int          T_RESET     = 40;
  localparam int          T_BUS       = 60;
  localparam int          T_FEED      = N_FEED + 30;
  localparam int          T_SAT       = N_SAT * (SAT_SMPS + 20);
  localparam int          T_LOOP      = LOOP_MAX + 60;
  localparam int          T_PWM       = PWM_PERIOD + 60;
  localparam int          WD_NS       = (RST_CYCLES + T_RESET + T_BUS + T_FEED + T_SAT
                                         + T_LOOP + T_PWM) * 2 * CLK_NS + 1000;

  logic                 adc_clk;
  logic                 reset_i;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  bus_adr_t             wb_adr_i;
  bus_sel_t             wb_sel_i;
  bus_dat_t             wb_dat_i;
  bus_dat_t             wb_dat_o;
  logic                 wb_ack_o;
  logic                 wb_err_o;
  adc_raw_t             adc_dat_a_i;
  adc_raw_t             adc_dat_b_i;
  dac_code_t            dac_dat_a_o;
  dac_code_t            dac_dat_b_o;
  logic [`RP_PWM_N-1:0] pwm_o;
  logic [7:0]           led_o;

  logic [31:0] rng_state;
  string       cur_test;
  int          err_cnt;
  int          test_err_base;
  int          pass_tests;
  int          fail_tests;
  int          hit_max;       // samples clamped high
  int          hit_min;       // samples clamped low

  rp_top dut_i (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
    .wb_adr_i (wb_adr_i), .wb_sel_i (wb_sel_i), .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o), .wb_err_o (wb_err_o),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o),
    .pwm_o (pwm_o), .led_o (led_o)
  );

  //////////////////////////////////////////////////////////////////////
  // checking and per test reporting
  //////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
  endtask

  task automatic finish_test();
    if (err_cnt == test_err_base)
    begin
      pass_tests++;
      $display("[test] %s: ok", cur_test);
    end
    else
    begin
      fail_tests++;
      $display("[test] %s: %0d errors", cur_test, err_cnt - test_err_base);
    end
  endtask

  `include "rp_tb_bus.svh"

  // random adc words in, dac words checked two cycles later
  task automatic stream_samples(input int n, input int ofs_a, input int ofs_b);
    adc_raw_t    q_a [$];
    adc_raw_t    q_b [$];
    logic [31:0] r;
    int          exp_a;
    int          exp_b;
    for (int i = 0; i < n + 2; i++)
    begin
      @(negedge adc_clk);
      if (i >= 2)
      begin
        exp_a = clamp_sum(adc_to_smp(q_a.pop_front()), ofs_a);
        exp_b = clamp_sum(adc_to_smp(q_b.pop_front()), ofs_b);
        check_eq("dac a", smp_to_code(exp_a), dac_dat_a_o);
        check_eq("dac b", smp_to_code(exp_b), dac_dat_b_o);
        hit_max += (exp_a == SMP_MAX) + (exp_b == SMP_MAX);
        hit_min += (exp_a == SMP_MIN) + (exp_b == SMP_MIN);
      end
      if (i < n)
      begin
        r = next_rand();
        adc_dat_a_i = r[15:0];
        adc_dat_b_i = r[31:16];
        q_a.push_back(r[15:0]);
        q_b.push_back(r[31:16]);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus answers, checked on every clock
  //////////////////////////////////////////////////////////////////////

  ack_err_excl: assert property (@(posedge adc_clk) disable iff (reset_i)
                                 !(wb_ack_o && wb_err_o))
  else
  begin
    $display("[ERROR] %s ack with err: expected 0, actual 1", cur_test);
    err_cnt++;
  end

  ack_pulse: assert property (@(posedge adc_clk) disable iff (reset_i)
                              wb_ack_o |=> !wb_ack_o)
  else
  begin
    $display("[ERROR] %s ack width: expected 0, actual 1", cur_test);
    err_cnt++;
  end

  err_pulse: assert property (@(posedge adc_clk) disable iff (reset_i)
                              wb_err_o |=> !wb_err_o)
  else
  begin
    $display("[ERROR] %s err width: expected 0, actual 1", cur_test);
    err_cnt++;
  end

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_NS/2) adc_clk = ~adc_clk;
  end

  initial
  begin
    #(WD_NS);
    $display("timeout: the run did not finish within %0d ns", WD_NS);
    $display("tests failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    bus_dat_t    rd;
    int          resp;
    int          lat;
    int          n_ack;
    int          n_err;
    logic [31:0] r;
    logic [7:0]  led_val;
    int          ofs_a;
    int          ofs_b;
    int          prev_a;
    int          prev_b;
    int          steps;
    pwm_duty_t   duty [`RP_PWM_N];
    int          high [`RP_PWM_N];

    reset_i     = 1'b1;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_adr_i    = '0;
    wb_sel_i    = '0;
    wb_dat_i    = '0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    rng_state   = SEED;
    err_cnt     = 0;
    pass_tests  = 0;
    fail_tests  = 0;
    hit_max     = 0;
    hit_min     = 0;
    cur_test    = "reset";
    repeat (RST_CYCLES) @(negedge adc_clk);
    reset_i = 1'b0;
    @(negedge adc_clk);

    // 1: rest values, id, led
    start_test("reset_id");
    check_eq("dac a at rest", smp_to_code(0), dac_dat_a_o);
    check_eq("dac b at rest", smp_to_code(0), dac_dat_b_o);
    check_eq("pwm at rest", 0, pwm_o);
    check_eq("led at rest", 0, led_o);
    check_eq("ack at rest", 0, wb_ack_o);
    check_eq("err at rest", 0, wb_err_o);
    read_reg(`RP_REGION_HK, `RP_HK_ID, rd);
    check_eq("id", `RP_HK_ID_VALUE, rd);
    r       = next_rand();
    led_val = r[7:0];
    write_reg(`RP_REGION_HK, `RP_HK_LED, bus_dat_t'(led_val));
    check_eq("led pins", led_val, led_o);
    read_reg(`RP_REGION_HK, `RP_HK_LED, rd);
    check_eq("led readback", led_val, rd);
    finish_test();

    // 2: unknown offsets acked, unmapped regions get err
    start_test("bus_protocol");
    read_reg(`RP_REGION_HK, 9, rd);
    check_eq("unknown hk word", 0, rd);
    write_reg(`RP_REGION_HK, 9, 32'hffff_ffff);     // must be ignored
    read_reg(`RP_REGION_HK, `RP_HK_CTRL, rd);
    check_eq("ctrl untouched", 0, rd);
    read_reg(`RP_REGION_PWM, 7, rd);
    check_eq("unknown pwm word", 0, rd);
    for (int reg_n = 2; reg_n < 16; reg_n += 6)
    begin
      wb_access(1'b0, reg_addr(reg_n, `RP_HK_ID), '0, rd, resp, lat);
      check_eq("unmapped read resp", 1, resp);
      check_eq("unmapped read latency", 1, lat);
      check_eq("unmapped read data", 0, rd);
      wb_access(1'b1, reg_addr(reg_n, `RP_HK_LED), 32'h0000_00ff, rd, resp, lat);
      check_eq("unmapped write resp", 1, resp);
    end
    check_eq("led after unmapped writes", led_val, led_o);
    // a strobe held past the answer still gets a single answer
    held_read(reg_addr(`RP_REGION_HK, `RP_HK_ID), n_ack, n_err);
    check_eq("held hk acks", 1, n_ack);
    check_eq("held hk errs", 0, n_err);
    held_read(reg_addr(`RP_REGION_PWM, 0), n_ack, n_err);
    check_eq("held pwm acks", 1, n_ack);
    check_eq("held pwm errs", 0, n_err);
    held_read(reg_addr(2, `RP_HK_ID), n_ack, n_err);
    check_eq("held unmapped acks", 0, n_ack);
    check_eq("held unmapped errs", 1, n_err);
    finish_test();

    // 3: adc straight through to the dac
    start_test("feedthrough");
    write_reg(`RP_REGION_HK, `RP_HK_CTRL,
              (1 << `RP_CTRL_FT_A_BIT) | (1 << `RP_CTRL_FT_B_BIT));
    stream_samples(N_FEED, 0, 0);
    finish_test();

    // 4: offsets added, first two batches drive both limits
    start_test("saturation");
    for (int b = 0; b < N_SAT; b++)
    begin
      r     = next_rand();
      ofs_a = (b == 0) ? SMP_MAX : (b == 1) ? SMP_MIN : int'($signed(r[13:0]));
      ofs_b = (b == 0) ? SMP_MIN : (b == 1) ? SMP_MAX : int'($signed(r[29:16]));
      write_reg(`RP_REGION_HK, `RP_HK_OFS_A, bus_dat_t'(ofs_a));
      write_reg(`RP_REGION_HK, `RP_HK_OFS_B, bus_dat_t'(ofs_b));
      stream_samples(SAT_SMPS, ofs_a, ofs_b);
    end
    assert (hit_max > 0 && hit_min > 0)
    else
    begin
      $display("%s: the stimulus never drove both saturation limits", cur_test);
      err_cnt++;
    end
    finish_test();

    // 5: dac register fed back, grows by the offset until clamped
    start_test("loopback");
    write_reg(`RP_REGION_HK, `RP_HK_CTRL, 0);
    r     = next_rand();
    ofs_a = 50 + r[6:0];
    ofs_b = 50 + r[22:16];
    write_reg(`RP_REGION_HK, `RP_HK_OFS_A, bus_dat_t'(ofs_a));
    write_reg(`RP_REGION_HK, `RP_HK_OFS_B, bus_dat_t'(ofs_b));
    write_reg(`RP_REGION_HK, `RP_HK_CTRL, (1 << `RP_CTRL_LOOP_BIT) |
              (1 << `RP_CTRL_FT_A_BIT) | (1 << `RP_CTRL_FT_B_BIT));
    prev_a = code_to_smp(dac_dat_a_o);
    prev_b = code_to_smp(dac_dat_b_o);
    steps  = 0;
    while ((prev_a != SMP_MAX || prev_b != SMP_MAX) && steps < LOOP_MAX)
    begin
      @(negedge adc_clk);
      check_eq("step a", smp_to_code(clamp_sum(prev_a, ofs_a)), dac_dat_a_o);
      check_eq("step b", smp_to_code(clamp_sum(prev_b, ofs_b)), dac_dat_b_o);
      prev_a = code_to_smp(dac_dat_a_o);
      prev_b = code_to_smp(dac_dat_b_o);
      steps++;
    end
    assert (steps < LOOP_MAX)
    else
    begin
      $display("%s: the dac output never reached the upper limit", cur_test);
      err_cnt++;
    end
    repeat (8)
    begin
      @(negedge adc_clk);
      check_eq("hold a", smp_to_code(SMP_MAX), dac_dat_a_o);
      check_eq("hold b", smp_to_code(SMP_MAX), dac_dat_b_o);
    end
    finish_test();

    // 6: high cycles per period equal the duty
    start_test("pwm_duty");
    for (int n = 0; n < `RP_PWM_N; n++)
    begin
      r       = next_rand();
      duty[n] = (n == 0) ? '0 : r[7:0];       // channel 0 always low
      write_reg(`RP_REGION_PWM, n, bus_dat_t'(duty[n]));
      read_reg(`RP_REGION_PWM, n, rd);
      check_eq($sformatf("duty readback ch%0d", n), duty[n], rd);
      high[n] = 0;
    end
    repeat (2) @(negedge adc_clk);
    repeat (PWM_PERIOD)
    begin
      @(negedge adc_clk);
      for (int n = 0; n < `RP_PWM_N; n++)
        high[n] += pwm_o[n];
    end
    for (int n = 0; n < `RP_PWM_N; n++)
      check_eq($sformatf("high cycles ch%0d", n), duty[n], high[n]);
    finish_test();

    $display("summary: %0d ok, %0d with errors, %0d errors in all",
             pass_tests, fail_tests, err_cnt);
    if (err_cnt == 0 && fail_tests == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule : rp_tb

//--- flist.f
+incdir+design
+incdir+verif
design/rp_bus_pkg.sv
design/rp_sample_pkg.sv
design/rp_bus_decoder.sv
design/rp_housekeeping.sv
design/rp_analog_io.sv
design/rp_pwm_dac.sv
design/rp_top.sv
verif/rp_tb.sv
